// ==== Bender.yml ====
package:
  name: jacobi

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/jacobi_types_pkg.sv
      - hw/jacobi_ctrl_pkg.sv
      - hw/jacobi_matrix_ram.sv
      - hw/jacobi_pair_sched.sv
      - hw/jacobi_addr_unit.sv
      - hw/jacobi_angle_operands.sv
      - hw/jacobi_ctrl.sv
      - hw/jacobi_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/jacobi_props.sv
      - sim/jacobi_tb.sv

// ==== hw/jacobi_addr_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "jacobi_params.svh"

module jacobi_addr_unit (
  input  jacobi_types_pkg::idx_t        idx_i_i,
  input  jacobi_types_pkg::idx_t        idx_j_i,
  input  jacobi_ctrl_pkg::fetch_phase_t phase_i,
  output jacobi_types_pkg::addr_t       addr_a_o,
  output jacobi_types_pkg::addr_t       addr_b_o
);

  // Row r of the packed upper triangle starts after r rows of shrinking length
  function automatic jacobi_types_pkg::addr_t tri_addr(jacobi_types_pkg::idx_t r,
                                                       jacobi_types_pkg::idx_t c);
    int rr;
    int cc;
    rr = int'(r);
    cc = int'(c);
    return jacobi_types_pkg::addr_t'(rr * `JACOBI_N - (rr * (rr - 1)) / 2 + cc - rr);
  endfunction

  always_comb begin
    if (phase_i == jacobi_ctrl_pkg::FETCH_DIAG_J) begin
      addr_a_o = tri_addr(idx_j_i, idx_j_i);
    end else begin
      addr_a_o = tri_addr(idx_i_i, idx_i_i);
    end
    addr_b_o = tri_addr(idx_i_i, idx_j_i);
  end

endmodule

`default_nettype wire

// ==== hw/jacobi_angle_operands.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "jacobi_params.svh"

module jacobi_angle_operands (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          fetch_en_i,
  input  jacobi_ctrl_pkg::fetch_phase_t phase_i,
  input  jacobi_types_pkg::word_t       ram_dout_a_i,
  input  jacobi_types_pkg::word_t       ram_dout_b_i,
  output jacobi_types_pkg::word_t       vec_x_o,
  output jacobi_types_pkg::word_t       vec_y_o,
  output logic                          vec_vld_o
);

  logic                          fetch_d1_r;
  logic                          fetch_d2_r;
  jacobi_ctrl_pkg::fetch_phase_t phase_d1_r;
  jacobi_ctrl_pkg::fetch_phase_t phase_d2_r;
  jacobi_types_pkg::word_t       x_r;
  jacobi_types_pkg::word_t       y_r;
  logic                          vld_r;

  // Address register plus memory read register
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_d1_r <= 1'b0;
      fetch_d2_r <= 1'b0;
      vld_r <= 1'b0;
    end else begin
      fetch_d1_r <= fetch_en_i;
      fetch_d2_r <= fetch_d1_r;
      vld_r <= fetch_d2_r && (phase_d2_r == jacobi_ctrl_pkg::FETCH_DIAG_I);
    end
  end

  always_ff @(posedge clk) begin
    phase_d1_r <= phase_i;
    phase_d2_r <= phase_d1_r;
    if (fetch_d2_r) begin
      if (phase_d2_r == jacobi_ctrl_pkg::FETCH_DIAG_J) begin
        x_r <= ram_dout_a_i;
        y_r <= ram_dout_b_i;
      end else begin
        // x = Wjj - Wii, y = 2 Wij
        x_r <= x_r - ram_dout_a_i;
        y_r <= y_r + ram_dout_b_i;
      end
    end
  end

  assign vec_x_o = x_r;
  assign vec_y_o = y_r;
  assign vec_vld_o = vld_r;

endmodule

`default_nettype wire

// ==== hw/jacobi_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "jacobi_params.svh"

module jacobi_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  input  jacobi_types_pkg::word_t       in_dat_i,
  input  logic                          in_vld_i,
  output logic                          in_rdy_o,
  input  logic                          out_rdy_i,
  output logic                          out_vld_o,
  output logic                          out_last_o,
  input  jacobi_types_pkg::addr_t       fetch_addr_a_i,
  input  jacobi_types_pkg::addr_t       fetch_addr_b_i,
  output logic                          ram_en_a_o,
  output logic                          ram_we_a_o,
  output jacobi_types_pkg::addr_t       ram_addr_a_o,
  output jacobi_types_pkg::word_t       ram_din_a_o,
  output logic                          ram_en_b_o,
  output jacobi_types_pkg::addr_t       ram_addr_b_o,
  output logic                          shift_o,
  output logic                          draw_o,
  output logic                          fetch_en_o,
  output jacobi_ctrl_pkg::fetch_phase_t phase_o
);

  localparam int IN_W = $clog2(`JACOBI_N_INPUT);
  localparam int PAIR_W = $clog2(`JACOBI_N_PAIRS);
  localparam int ROUND_W = $clog2(`JACOBI_N_ROUNDS);
  localparam logic [IN_W-1:0] IN_LAST = IN_W'(`JACOBI_N_INPUT - 1);
  localparam logic [PAIR_W-1:0] PAIR_LAST = PAIR_W'(`JACOBI_N_PAIRS - 1);
  localparam logic [ROUND_W-1:0] ROUND_LAST = ROUND_W'(`JACOBI_N_ROUNDS - 1);
  localparam jacobi_types_pkg::idx_t IDX_LAST = jacobi_types_pkg::idx_t'(`JACOBI_N - 1);
  // Last operand pulse has left the pipeline after three cycles
  localparam logic [1:0] DRAIN_LAST = 2'd2;

  jacobi_ctrl_pkg::main_state_t state_r;
  jacobi_types_pkg::idx_t       init_row_r;
  jacobi_types_pkg::idx_t       init_col_r;
  logic [IN_W-1:0]              in_cnt_r;
  logic                         push_phase_r;
  logic [PAIR_W-1:0]            pair_cnt_r;
  logic [1:0]                   drain_cnt_r;
  logic [ROUND_W-1:0]           round_r;
  jacobi_types_pkg::addr_t      send_addr_r;
  logic                         send_end_r;
  logic                         en_a_r;
  logic                         we_a_r;
  logic                         en_b_r;
  jacobi_types_pkg::addr_t      addr_a_r;
  jacobi_types_pkg::addr_t      addr_b_r;
  jacobi_types_pkg::word_t      din_a_r;
  logic                         out_vld_r;
  logic                         out_last_r;
  logic                         accept;
  logic                         send_state;
  logic                         send_issue;

  assign in_rdy_o = (state_r == jacobi_ctrl_pkg::IDLE) || (state_r == jacobi_ctrl_pkg::RECEIVE);
  assign accept = in_rdy_o && in_vld_i;
  assign fetch_en_o = (state_r == jacobi_ctrl_pkg::PUSH);
  assign phase_o = push_phase_r ? jacobi_ctrl_pkg::FETCH_DIAG_I : jacobi_ctrl_pkg::FETCH_DIAG_J;
  assign shift_o = fetch_en_o && push_phase_r;
  assign draw_o = (state_r == jacobi_ctrl_pkg::DRAW);

  // Read only into an empty output stage or one that is being taken
  assign send_state = (state_r == jacobi_ctrl_pkg::SEND);
  assign send_issue = send_state && !send_end_r && (!out_vld_r || out_rdy_i);

  assign ram_en_a_o = send_state ? send_issue : en_a_r;
  assign ram_addr_a_o = send_state ? send_addr_r : addr_a_r;
  assign ram_we_a_o = we_a_r;
  assign ram_din_a_o = din_a_r;
  assign ram_en_b_o = en_b_r;
  assign ram_addr_b_o = addr_b_r;
  assign out_vld_o = out_vld_r;
  assign out_last_o = out_last_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_r <= jacobi_ctrl_pkg::INIT;
      en_a_r <= 1'b0;
      we_a_r <= 1'b0;
      en_b_r <= 1'b0;
    end else begin
      en_a_r <= 1'b0;
      we_a_r <= 1'b0;
      en_b_r <= 1'b0;
      case (state_r)
        jacobi_ctrl_pkg::INIT: begin
          // Identity into V in row-major order
          en_a_r <= 1'b1;
          we_a_r <= 1'b1;
          addr_a_r <= jacobi_types_pkg::addr_t'(`JACOBI_V_OFFSET)
                      + jacobi_types_pkg::addr_t'({init_row_r, init_col_r});
          din_a_r <= (init_row_r == init_col_r) ? jacobi_types_pkg::word_t'(`JACOBI_ONE) : '0;
          if (init_row_r == IDX_LAST && init_col_r == IDX_LAST) begin
            state_r <= jacobi_ctrl_pkg::IDLE;
          end
        end
        jacobi_ctrl_pkg::IDLE, jacobi_ctrl_pkg::RECEIVE: begin
          if (accept) begin
            en_a_r <= 1'b1;
            we_a_r <= 1'b1;
            addr_a_r <= jacobi_types_pkg::addr_t'(in_cnt_r);
            din_a_r <= in_dat_i;
            state_r <= (in_cnt_r == IN_LAST) ? jacobi_ctrl_pkg::PUSH : jacobi_ctrl_pkg::RECEIVE;
          end
        end
        jacobi_ctrl_pkg::PUSH: begin
          en_a_r <= 1'b1;
          en_b_r <= 1'b1;
          addr_a_r <= fetch_addr_a_i;
          addr_b_r <= fetch_addr_b_i;
          if (push_phase_r && pair_cnt_r == PAIR_LAST) begin
            state_r <= jacobi_ctrl_pkg::DRAIN;
          end
        end
        jacobi_ctrl_pkg::DRAIN: begin
          if (drain_cnt_r == DRAIN_LAST) begin
            state_r <= jacobi_ctrl_pkg::DRAW;
          end
        end
        jacobi_ctrl_pkg::DRAW: begin
          state_r <= (round_r == ROUND_LAST) ? jacobi_ctrl_pkg::SEND : jacobi_ctrl_pkg::PUSH;
        end
        jacobi_ctrl_pkg::SEND: begin
          // Leave only once the final word is taken
          if (out_vld_r && out_last_r && out_rdy_i) begin
            state_r <= jacobi_ctrl_pkg::INIT;
          end
        end
        default: begin
          state_r <= jacobi_ctrl_pkg::INIT;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      init_row_r <= '0;
      init_col_r <= '0;
      in_cnt_r <= '0;
    end else begin
      if (state_r == jacobi_ctrl_pkg::INIT) begin
        init_col_r <= init_col_r + 1'b1;
        if (init_col_r == IDX_LAST) begin
          init_row_r <= init_row_r + 1'b1;
        end
      end
      if (accept) begin
        in_cnt_r <= (in_cnt_r == IN_LAST) ? '0 : in_cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      push_phase_r <= 1'b0;
      pair_cnt_r <= '0;
      drain_cnt_r <= '0;
      round_r <= '0;
    end else begin
      if (fetch_en_o) begin
        push_phase_r <= !push_phase_r;
        if (push_phase_r) begin
          pair_cnt_r <= pair_cnt_r + 1'b1;
        end
      end else begin
        push_phase_r <= 1'b0;
        pair_cnt_r <= '0;
      end
      drain_cnt_r <= (state_r == jacobi_ctrl_pkg::DRAIN) ? drain_cnt_r + 1'b1 : 2'd0;
      if (draw_o) begin
        round_r <= (round_r == ROUND_LAST) ? '0 : round_r + 1'b1;
      end
    end
  end

  // Unload counter skips the unused gap between A and V
  always_ff @(posedge clk) begin
    if (rst) begin
      send_addr_r <= '0;
      send_end_r <= 1'b0;
      out_vld_r <= 1'b0;
      out_last_r <= 1'b0;
    end else begin
      if (send_issue) begin
        if (send_addr_r == jacobi_types_pkg::addr_t'(`JACOBI_N_INPUT - 1)) begin
          send_addr_r <= jacobi_types_pkg::addr_t'(`JACOBI_V_OFFSET);
        end else begin
          send_addr_r <= send_addr_r + 1'b1;
        end
        if (send_addr_r == '1) begin
          send_end_r <= 1'b1;
        end
      end else if (!send_state) begin
        send_end_r <= 1'b0;
      end
      if (!out_vld_r || out_rdy_i) begin
        out_vld_r <= send_issue;
        out_last_r <= send_issue && (send_addr_r == '1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/jacobi_ctrl_pkg.sv ====
`default_nettype none

package jacobi_ctrl_pkg;

  typedef enum logic [2:0] {INIT, IDLE, RECEIVE, PUSH, DRAIN, DRAW, SEND} main_state_t;

  // Which diagonal element port a reads
  typedef enum logic {FETCH_DIAG_J, FETCH_DIAG_I} fetch_phase_t;

endpackage

`default_nettype wire

// ==== hw/jacobi_matrix_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "jacobi_params.svh"

module jacobi_matrix_ram (
  input  logic                    clk,
  input  logic                    en_a_i,
  input  logic                    we_a_i,
  input  jacobi_types_pkg::addr_t addr_a_i,
  input  jacobi_types_pkg::word_t din_a_i,
  output jacobi_types_pkg::word_t dout_a_o,
  input  logic                    en_b_i,
  input  jacobi_types_pkg::addr_t addr_b_i,
  output jacobi_types_pkg::word_t dout_b_o
);

  jacobi_types_pkg::word_t mem [2**`JACOBI_ADDR_W];

  // Read-first on port a
  always_ff @(posedge clk) begin
    if (en_a_i) begin
      if (we_a_i) begin
        mem[addr_a_i] <= din_a_i;
      end
      dout_a_o <= mem[addr_a_i];
    end
  end

  always_ff @(posedge clk) begin
    if (en_b_i) begin
      dout_b_o <= mem[addr_b_i];
    end
  end

endmodule

`default_nettype wire

// ==== hw/jacobi_pair_sched.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "jacobi_params.svh"

module jacobi_pair_sched (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   shift_i,
  input  logic                   draw_i,
  output jacobi_types_pkg::idx_t idx_i_o,
  output jacobi_types_pkg::idx_t idx_j_o
);

  jacobi_types_pkg::idx_t slot_r [`JACOBI_N_PAIRS][2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < `JACOBI_N_PAIRS; p++) begin
        slot_r[p][0] <= jacobi_types_pkg::idx_t'(p);
        slot_r[p][1] <= jacobi_types_pkg::idx_t'(`JACOBI_N - 1 - p);
      end
    end else if (draw_i) begin
      // Tournament step keeps slot 0 element 0 in place
      slot_r[1][0] <= slot_r[2][0];
      slot_r[2][0] <= slot_r[3][0];
      slot_r[3][0] <= slot_r[3][1];
      slot_r[3][1] <= slot_r[2][1];
      slot_r[2][1] <= slot_r[1][1];
      slot_r[1][1] <= slot_r[0][1];
      slot_r[0][1] <= slot_r[1][0];
    end else if (shift_i) begin
      for (int p = 0; p < `JACOBI_N_PAIRS; p++) begin
        slot_r[p] <= slot_r[(p + 1) % `JACOBI_N_PAIRS];
      end
    end
  end

  // Active pair with the smaller index first
  always_comb begin
    if (slot_r[0][0] < slot_r[0][1]) begin
      idx_i_o = slot_r[0][0];
      idx_j_o = slot_r[0][1];
    end else begin
      idx_i_o = slot_r[0][1];
      idx_j_o = slot_r[0][0];
    end
  end

endmodule

`default_nettype wire

// ==== hw/jacobi_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "jacobi_params.svh"

module jacobi_top (
  input  logic                    clk,
  input  logic                    rst,
  input  jacobi_types_pkg::word_t in_dat_i,
  input  logic                    in_vld_i,
  output logic                    in_rdy_o,
  output jacobi_types_pkg::word_t vec_x_o,
  output jacobi_types_pkg::word_t vec_y_o,
  output logic                    vec_vld_o,
  output jacobi_types_pkg::word_t out_dat_o,
  output logic                    out_vld_o,
  output logic                    out_last_o,
  input  logic                    out_rdy_i
);

  logic                           ram_en_a;
  logic                           ram_we_a;
  jacobi_types_pkg::addr_t        ram_addr_a;
  jacobi_types_pkg::word_t        ram_din_a;
  jacobi_types_pkg::word_t        ram_dout_a;
  logic                           ram_en_b;
  jacobi_types_pkg::addr_t        ram_addr_b;
  jacobi_types_pkg::word_t        ram_dout_b;
  jacobi_types_pkg::addr_t        fetch_addr_a;
  jacobi_types_pkg::addr_t        fetch_addr_b;
  logic                           shift;
  logic                           draw;
  logic                           fetch_en;
  jacobi_ctrl_pkg::fetch_phase_t  phase;
  jacobi_types_pkg::idx_t         idx_i;
  jacobi_types_pkg::idx_t         idx_j;

  jacobi_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .in_dat_i       (in_dat_i),
    .in_vld_i       (in_vld_i),
    .in_rdy_o       (in_rdy_o),
    .out_rdy_i      (out_rdy_i),
    .out_vld_o      (out_vld_o),
    .out_last_o     (out_last_o),
    .fetch_addr_a_i (fetch_addr_a),
    .fetch_addr_b_i (fetch_addr_b),
    .ram_en_a_o     (ram_en_a),
    .ram_we_a_o     (ram_we_a),
    .ram_addr_a_o   (ram_addr_a),
    .ram_din_a_o    (ram_din_a),
    .ram_en_b_o     (ram_en_b),
    .ram_addr_b_o   (ram_addr_b),
    .shift_o        (shift),
    .draw_o         (draw),
    .fetch_en_o     (fetch_en),
    .phase_o        (phase)
  );

  jacobi_pair_sched u_pair_sched (
    .clk     (clk),
    .rst     (rst),
    .shift_i (shift),
    .draw_i  (draw),
    .idx_i_o (idx_i),
    .idx_j_o (idx_j)
  );

  jacobi_addr_unit u_addr_unit (
    .idx_i_i  (idx_i),
    .idx_j_i  (idx_j),
    .phase_i  (phase),
    .addr_a_o (fetch_addr_a),
    .addr_b_o (fetch_addr_b)
  );

  jacobi_angle_operands u_angle_operands (
    .clk          (clk),
    .rst          (rst),
    .fetch_en_i   (fetch_en),
    .phase_i      (phase),
    .ram_dout_a_i (ram_dout_a),
    .ram_dout_b_i (ram_dout_b),
    .vec_x_o      (vec_x_o),
    .vec_y_o      (vec_y_o),
    .vec_vld_o    (vec_vld_o)
  );

  jacobi_matrix_ram u_matrix_ram (
    .clk      (clk),
    .en_a_i   (ram_en_a),
    .we_a_i   (ram_we_a),
    .addr_a_i (ram_addr_a),
    .din_a_i  (ram_din_a),
    .dout_a_o (ram_dout_a),
    .en_b_i   (ram_en_b),
    .addr_b_i (ram_addr_b),
    .dout_b_o (ram_dout_b)
  );

  // Unload words come straight from the port a read register
  assign out_dat_o = ram_dout_a;

endmodule

`default_nettype wire

// ==== hw/jacobi_types_pkg.sv ====
`default_nettype none

`include "jacobi_params.svh"

package jacobi_types_pkg;

  // Signed fixed-point matrix element
  typedef logic signed [`JACOBI_WORD_W-1:0] word_t;

  typedef logic [`JACOBI_ADDR_W-1:0] addr_t;

  // Row or column index
  typedef logic [$clog2(`JACOBI_N)-1:0] idx_t;

endpackage

`default_nettype wire

// ==== include/jacobi_params.svh ====
`ifndef JACOBI_PARAMS_SVH
`define JACOBI_PARAMS_SVH

// Matrix order and round-robin schedule size
`define JACOBI_N        8
`define JACOBI_N_PAIRS  4
`define JACOBI_N_ROUNDS 7

`define JACOBI_WORD_W   16
`define JACOBI_ADDR_W   7

// Upper triangle of A is packed at 0..35, V is a full 8x8 block
`define JACOBI_N_INPUT  36
`define JACOBI_V_OFFSET 64

`define JACOBI_ONE      (1 << 15)

`endif

// ==== jacobi_top.f ====
+incdir+include
hw/jacobi_types_pkg.sv
hw/jacobi_ctrl_pkg.sv
hw/jacobi_matrix_ram.sv
hw/jacobi_pair_sched.sv
hw/jacobi_addr_unit.sv
hw/jacobi_angle_operands.sv
hw/jacobi_ctrl.sv
hw/jacobi_top.sv
sim/jacobi_props.sv
sim/jacobi_tb.sv

// ==== sim/jacobi_props.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "jacobi_params.svh"

module jacobi_props (
  input logic                    clk,
  input logic                    rst,
  input logic                    in_vld_i,
  input logic                    in_rdy_o,
  input logic                    vec_vld_o,
  input jacobi_types_pkg::word_t out_dat_o,
  input logic                    out_vld_o,
  input logic                    out_last_o,
  input logic                    out_rdy_i
);

  localparam int INIT_CYCLES = `JACOBI_N * `JACOBI_N;

  logic [5:0] acc_cnt_r;
  logic [6:0] cyc_r;
  int         fail_cnt = 0;

  // Accept count and a cycle count that stops at the end of init
  always_ff @(posedge clk) begin
    if (rst) begin
      acc_cnt_r <= '0;
      cyc_r <= '0;
    end else begin
      if (in_vld_i && in_rdy_o) begin
        acc_cnt_r <= acc_cnt_r + 1'b1;
      end
      if (cyc_r < 7'(INIT_CYCLES)) begin
        cyc_r <= cyc_r + 1'b1;
      end
    end
  end

  vec_pulse_single: assert property (@(posedge clk) disable iff (rst)
    vec_vld_o |=> !vec_vld_o)
    else begin
      $error("vec_vld_o lasted more than one cycle");
      fail_cnt++;
    end

  out_hold: assert property (@(posedge clk) disable iff (rst)
    out_vld_o && !out_rdy_i |=> out_vld_o && $stable(out_dat_o) && $stable(out_last_o))
    else begin
      $error("output stage changed while out_rdy_i was low");
      fail_cnt++;
    end

  in_rdy_init: assert property (@(posedge clk) disable iff (rst)
    cyc_r < 7'(INIT_CYCLES) |-> !in_rdy_o)
    else begin
      $error("in_rdy_o high during identity init");
      fail_cnt++;
    end

  in_rdy_done: assert property (@(posedge clk) disable iff (rst)
    in_vld_i && in_rdy_o && acc_cnt_r == 6'(`JACOBI_N_INPUT - 1) |=> !in_rdy_o)
    else begin
      $error("in_rdy_o still high after the last input word");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== sim/jacobi_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "jacobi_params.svh"

module jacobi_tb;

  localparam int N_VEC = `JACOBI_N_PAIRS * `JACOBI_N_ROUNDS;
  localparam int N_OUT = `JACOBI_N_INPUT + `JACOBI_N * `JACOBI_N;
  // Reset and init, load, 12 cycles per round, unload under random back-pressure
  localparam int WATCHDOG_CYCLES = 200 + `JACOBI_N_INPUT + `JACOBI_N_ROUNDS * 12 + N_OUT * 4;

  logic                    clk;
  logic                    rst;
  jacobi_types_pkg::word_t in_dat;
  logic                    in_vld;
  logic                    in_rdy;
  jacobi_types_pkg::word_t vec_x;
  jacobi_types_pkg::word_t vec_y;
  logic                    vec_vld;
  jacobi_types_pkg::word_t out_dat;
  logic                    out_vld;
  logic                    out_last;
  logic                    out_rdy;

  integer                  seed;
  int                      vec_cnt = 0;
  int                      out_cnt = 0;
  jacobi_types_pkg::word_t in_words [$];
  jacobi_types_pkg::word_t exp_x [$];
  jacobi_types_pkg::word_t exp_y [$];
  int                      exp_round [$];
  int                      exp_pair [$];

  jacobi_top dut (
    .clk        (clk),
    .rst        (rst),
    .in_dat_i   (in_dat),
    .in_vld_i   (in_vld),
    .in_rdy_o   (in_rdy),
    .vec_x_o    (vec_x),
    .vec_y_o    (vec_y),
    .vec_vld_o  (vec_vld),
    .out_dat_o  (out_dat),
    .out_vld_o  (out_vld),
    .out_last_o (out_last),
    .out_rdy_i  (out_rdy)
  );

  bind jacobi_top jacobi_props u_props (
    .clk        (clk),
    .rst        (rst),
    .in_vld_i   (in_vld_i),
    .in_rdy_o   (in_rdy_o),
    .vec_vld_o  (vec_vld_o),
    .out_dat_o  (out_dat_o),
    .out_vld_o  (out_vld_o),
    .out_last_o (out_last_o),
    .out_rdy_i  (out_rdy_i)
  );

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input jacobi_types_pkg::word_t exp,
                            input jacobi_types_pkg::word_t act);
    if (act !== exp) begin
      report_error($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_error($sformatf("FAIL %s: expected %0b, actual %0b", name, exp, act));
    end
  endtask

  // Lines are tagged in, vec or # for a comment
  task automatic load_tests();
    int            fd;
    int            n;
    int            v [4];
    logic [8*16-1:0] tag;
    logic [8*128-1:0] skip;
    fd = $fopen("sim/jacobi_tests.txt", "r");
    if (fd == 0) begin
      report_error("Cannot open the test file sim/jacobi_tests.txt");
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", tag);
      if (n == 1) begin
        if (tag == "#") begin
          n = $fgets(skip, fd);
        end else if (tag == "in") begin
          n = $fscanf(fd, "%d %d %d %d", v[0], v[1], v[2], v[3]);
          for (int k = 0; k < n; k++) begin
            in_words.push_back(jacobi_types_pkg::word_t'(v[k]));
          end
        end else if (tag == "vec") begin
          n = $fscanf(fd, "%d %d %d %d", v[0], v[1], v[2], v[3]);
          exp_round.push_back(v[0]);
          exp_pair.push_back(v[1]);
          exp_x.push_back(jacobi_types_pkg::word_t'(v[2]));
          exp_y.push_back(jacobi_types_pkg::word_t'(v[3]));
        end else begin
          report_error("The test file holds a line with an unknown tag");
        end
      end
    end
    $fclose(fd);
    if (in_words.size() != `JACOBI_N_INPUT || exp_x.size() != N_VEC) begin
      report_error("The test file holds the wrong number of words or operand pairs");
    end
  endtask

  // Identity init takes one cycle per V element
  task automatic check_init_window();
    repeat (`JACOBI_N * `JACOBI_N) begin
      @(negedge clk);
      if (in_rdy) begin
        report_error("in_rdy_o rose before the identity init was done");
      end
    end
    @(negedge clk);
    if (!in_rdy) begin
      report_error("in_rdy_o did not rise after the identity init");
    end
  endtask

  task automatic load_matrix();
    int k;
    k = 0;
    while (k < `JACOBI_N_INPUT) begin
      @(posedge clk);
      in_vld <= (($random(seed) & 3) != 0);
      in_dat <= in_words[k];
      @(negedge clk);
      if (in_vld && in_rdy) begin
        k++;
      end
    end
    @(posedge clk);
    in_vld <= 1'b0;
    @(negedge clk);
    if (in_rdy) begin
      report_error("in_rdy_o stayed high after the last input word");
    end
  endtask

  task automatic unload_with_backpressure();
    while (out_cnt < N_OUT) begin
      @(posedge clk);
      out_rdy <= (($random(seed) & 1) != 0);
      @(negedge clk);
    end
  endtask

  task automatic check_out_word(input int idx);
    int                      v;
    jacobi_types_pkg::word_t exp;
    if (idx >= N_OUT) begin
      report_error("More output words were sent than the matrix holds");
    end
    if (idx < `JACOBI_N_INPUT) begin
      exp = in_words[idx];
    end else begin
      v = idx - `JACOBI_N_INPUT;
      exp = (v / `JACOBI_N == v % `JACOBI_N) ? jacobi_types_pkg::word_t'(`JACOBI_ONE) : '0;
    end
    check_word($sformatf("output word %0d", idx), exp, out_dat);
    check_flag($sformatf("output last %0d", idx), idx == N_OUT - 1, out_last);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    forever begin
      @(negedge clk);
      if (vec_vld === 1'b1) begin
        if (vec_cnt >= N_VEC) begin
          report_error("More vectoring operand pulses came than pairs were scheduled");
        end
        check_word($sformatf("round %0d pair %0d x", exp_round[vec_cnt], exp_pair[vec_cnt]),
                   exp_x[vec_cnt], vec_x);
        check_word($sformatf("round %0d pair %0d y", exp_round[vec_cnt], exp_pair[vec_cnt]),
                   exp_y[vec_cnt], vec_y);
        vec_cnt++;
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      if (out_vld === 1'b1 && out_rdy === 1'b1) begin
        check_out_word(out_cnt);
        out_cnt++;
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      if (dut.u_props.fail_cnt != 0) begin
        report_error("A bound assertion on the handshake or pulse rules failed");
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_error($sformatf("Timeout after %0d cycles with %0d pulses and %0d words seen",
                           WATCHDOG_CYCLES, vec_cnt, out_cnt));
  end

  initial begin
    seed = 32'h8738_2efb;
    rst = 1'b1;
    in_dat = '0;
    in_vld = 1'b0;
    out_rdy = 1'b0;
    load_tests();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    check_init_window();
    load_matrix();
    unload_with_backpressure();
    // Keep the output open so a late extra word would show
    @(posedge clk);
    out_rdy <= 1'b1;
    repeat (20) @(negedge clk);
    if (vec_cnt != N_VEC) begin
      report_error($sformatf("Saw %0d vectoring pulses instead of %0d", vec_cnt, N_VEC));
    end else if (dut.u_props.fail_cnt != 0) begin
      report_error($sformatf("%0d bound assertions failed", dut.u_props.fail_cnt));
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sim/jacobi_tests.txt ====
# in w0 w1 w2 w3 : four input words of A, packed upper triangle order
# vec round pair x y : expected vectoring operands, x = Wjj - Wii and y = 2 Wij
in -50 -49 -48 -47
in -46 -45 -44 -43
in -33 -32 -31 -30
in -29 -28 -27 -16
in -15 -14 -13 -12
in -11 1 2 3
in 4 5 18 19
in 20 21 35 36
in 37 52 53 69
vec 0 0 119 -86
vec 0 1 85 -56
vec 0 2 51 -26
vec 0 3 17 4
vec 1 0 17 -98
vec 1 1 85 -22
vec 1 2 51 8
vec 1 3 17 38
vec 2 0 34 -96
vec 2 1 34 -62
vec 2 2 51 42
vec 2 3 17 72
vec 3 0 51 -94
vec 3 1 34 -28
vec 3 2 68 -58
vec 3 3 17 106
vec 4 0 68 -92
vec 4 1 34 6
vec 4 2 68 -24
vec 4 3 102 -54
vec 5 0 85 -90
vec 5 1 34 40
vec 5 2 68 10
vec 5 3 17 -64
vec 6 0 102 -88
vec 6 1 34 74
vec 6 2 51 -60
vec 6 3 17 -30
